//--- logic/vfu_params.svh
// Sizes assume a 32-bit element and power-of-two lane and word counts
`ifndef VFU_PARAMS_SVH
`define VFU_PARAMS_SVH

////////////////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////////////////

// Parallel integer lanes, each one element word wide
`define VFU_N_LANES 2

// Lane width in bits
`define VFU_ELEN 32

////////////////////////////////////////////////////////////
// Register file and bookkeeping
////////////////////////////////////////////////////////////

// Architectural vector registers
`define VFU_NR_VREGS 32

// VRF words that make up one vector register
`define VFU_WORDS_PER_VREG 4

// Instruction id width
`define VFU_ID_W 3

`endif

//--- logic/vfu_pkg.sv
// Types for the vfu; vl never exceeds the elements of one vector register at the given SEW
`default_nettype none

`include "vfu_params.svh"

package vfu_pkg;

  typedef logic [`VFU_ELEN-1:0]                                 elen_t;
  typedef logic [`VFU_N_LANES*`VFU_ELEN-1:0]                    vword_t;
  typedef logic [`VFU_N_LANES*`VFU_ELEN/8-1:0]                  vbe_t;
  typedef logic [$clog2(`VFU_NR_VREGS*`VFU_WORDS_PER_VREG)-1:0] vaddr_t;
  // One spare bit so that count plus one word never wraps
  typedef logic [$clog2(`VFU_WORDS_PER_VREG*`VFU_N_LANES*4):0]  vlen_t;
  typedef logic [`VFU_ID_W-1:0]                                 vid_t;
  typedef logic [$clog2(`VFU_NR_VREGS)-1:0]                     vreg_t;
  // RISC-V integer register index
  typedef logic [4:0]                                           gpr_t;

  typedef enum logic [1:0] {EW_8, EW_16, EW_32} vew_e;

  typedef enum logic [2:0] {VADD, VSUB, VAND, VOR, VXOR, VMIN, VMAX} vop_e;

  typedef struct packed {
    vid_t  id;
    vop_e  op;
    vew_e  sew;
    vlen_t vl;
    vreg_t vs1;
    vreg_t vs2;
    vreg_t vd;
    gpr_t  rd;
    elen_t rs1;
    elen_t rs2;
    logic  use_vs1;
    logic  is_scalar;
  } vfu_req_t;

  // Travels with every word through the lanes
  typedef struct packed {
    vaddr_t waddr;
    vew_e   sew;
    vlen_t  nelem;
    logic   wb;
    logic   last;
  } vfu_tag_t;

  typedef struct packed {
    vid_t  id;
    gpr_t  rd;
    logic  wb;
    elen_t result;
  } vfu_rsp_t;

  // Elements held by one VRF word at a given SEW
  function automatic vlen_t elems_per_word(vew_e sew);
    return vlen_t'(`VFU_N_LANES) << (EW_32 - sew);
  endfunction

endpackage

`default_nettype wire

//--- logic/vfu_decode.sv
// Purely combinational; a scalar request uses lane 0 only and always counts as one element
`timescale 1ns/1ps
`default_nettype none

`include "vfu_params.svh"

module vfu_decode (
  input  vfu_pkg::vfu_req_t       req_i,
  input  vfu_pkg::vword_t   [1:0] vrf_rdata_i,
  input  vfu_pkg::vaddr_t         waddr_i,
  input  vfu_pkg::vlen_t          elem_cnt_i,
  input  logic                    issue_i,
  output vfu_pkg::vword_t         op1_o,
  output vfu_pkg::vword_t         op2_o,
  output vfu_pkg::vfu_tag_t       tag_o,
  output logic [`VFU_N_LANES-1:0] lane_valid_o
);
  import vfu_pkg::*;

  vword_t rs1_rep;
  vlen_t  remaining;
  vlen_t  epw;

  // Scalar operand spread over every element of the word
  always_comb begin : rep_proc
    unique case (req_i.sew)
      EW_8:    rs1_rep = {(`VFU_N_LANES*4){req_i.rs1[7:0]}};
      EW_16:   rs1_rep = {(`VFU_N_LANES*2){req_i.rs1[15:0]}};
      default: rs1_rep = {`VFU_N_LANES{req_i.rs1}};
    endcase
  end

  always_comb begin : operand_proc
    if (req_i.is_scalar) begin
      op1_o = vword_t'(req_i.rs1);
      op2_o = vword_t'(req_i.rs2);
    end else begin
      op1_o = req_i.use_vs1 ? vrf_rdata_i[1] : rs1_rep;
      op2_o = vrf_rdata_i[0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Word tag
  ////////////////////////////////////////////////////////////

  assign epw       = elems_per_word(req_i.sew);
  assign remaining = req_i.vl - elem_cnt_i;

  always_comb begin : tag_proc
    tag_o.waddr = waddr_i;
    tag_o.sew   = req_i.sew;
    tag_o.wb    = req_i.is_scalar;
    tag_o.last  = req_i.is_scalar || (remaining <= epw);
    if (req_i.is_scalar) begin
      tag_o.nelem = vlen_t'(1);
    end else begin
      tag_o.nelem = (remaining > epw) ? epw : remaining;
    end
  end

  // Scalar work stays on lane 0
  always_comb begin : lane_en_proc
    for (int l = 0; l < `VFU_N_LANES; l++) begin
      lane_valid_o[l] = issue_i && (!req_i.is_scalar || l == 0);
    end
  end

endmodule

`default_nettype wire

//--- logic/vfu_sequencer.sv
// One instruction at a time; the next one starts only after the previous response is taken
`timescale 1ns/1ps
`default_nettype none

`include "vfu_params.svh"

module vfu_sequencer (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  vfu_pkg::vfu_req_t       req_i,
  input  logic                    req_valid_i,
  input  logic              [1:0] vrf_rvalid_i,
  input  logic                    rsp_ready_i,
  input  logic                    rsp_accepted_i,
  output logic                    req_done_o,
  output logic              [1:0] vrf_re_o,
  output vfu_pkg::vaddr_t   [1:0] vrf_raddr_o,
  output vfu_pkg::vaddr_t         waddr_o,
  output vfu_pkg::vlen_t          elem_cnt_o,
  output logic                    issue_o
);
  import vfu_pkg::*;

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_ISSUE, SEQ_WAIT_RSP} seq_state_e;

  seq_state_e   state_q;
  seq_state_e   state_d;
  // Word pointers for vs2, vs1 and vd
  vaddr_t [2:0] addr_q;
  vlen_t        elem_cnt_q;
  logic         ops_ready;
  logic         last_word;

  // Scalar requests read nothing from the VRF
  assign vrf_re_o  = (state_q == SEQ_ISSUE && !req_i.is_scalar) ? {req_i.use_vs1, 1'b1} : 2'b00;
  assign ops_ready = (!vrf_re_o[0] || vrf_rvalid_i[0]) && (!vrf_re_o[1] || vrf_rvalid_i[1]);
  assign issue_o   = (state_q == SEQ_ISSUE) && ops_ready && (!req_i.is_scalar || rsp_ready_i);
  assign last_word = req_i.is_scalar || (elem_cnt_q + elems_per_word(req_i.sew) >= req_i.vl);

  assign req_done_o  = (state_q == SEQ_WAIT_RSP) && rsp_accepted_i;
  assign vrf_raddr_o = addr_q[1:0];
  assign waddr_o     = addr_q[2];
  assign elem_cnt_o  = elem_cnt_q;

  always_comb begin : fsm_proc
    state_d = state_q;
    unique case (state_q)
      SEQ_IDLE:     if (req_valid_i) state_d = SEQ_ISSUE;
      SEQ_ISSUE:    if (issue_o && last_word) state_d = SEQ_WAIT_RSP;
      SEQ_WAIT_RSP: if (rsp_accepted_i) state_d = SEQ_IDLE;
      default:      state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= SEQ_IDLE;
      addr_q     <= '0;
      elem_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == SEQ_IDLE && req_valid_i) begin
        // Every operand starts at word 0 of its register
        addr_q[0]  <= vaddr_t'(req_i.vs2 * `VFU_WORDS_PER_VREG);
        addr_q[1]  <= vaddr_t'(req_i.vs1 * `VFU_WORDS_PER_VREG);
        addr_q[2]  <= vaddr_t'(req_i.vd * `VFU_WORDS_PER_VREG);
        elem_cnt_q <= '0;
      end else if (issue_o) begin
        addr_q[0]  <= addr_q[0] + 1'b1;
        addr_q[1]  <= addr_q[1] + 1'b1;
        addr_q[2]  <= addr_q[2] + 1'b1;
        elem_cnt_q <= elem_cnt_q + elems_per_word(req_i.sew);
      end
    end
  end

  // A vector request waits for its response only once all of vl has issued
  a_wait_covers_vl : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (state_q == SEQ_WAIT_RSP && !req_i.is_scalar) |-> (elem_cnt_q >= req_i.vl)
  );

endmodule

`default_nettype wire

//--- logic/vfu_lane.sv
// Fixed two-cycle latency with no stall input; subword results never carry into their neighbour
`timescale 1ns/1ps
`default_nettype none

`include "vfu_params.svh"

module vfu_lane (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              valid_i,
  input  vfu_pkg::vop_e     op_i,
  input  vfu_pkg::vew_e     sew_i,
  input  vfu_pkg::elen_t    a_i,
  input  vfu_pkg::elen_t    b_i,
  input  vfu_pkg::vfu_tag_t tag_i,
  output logic              valid_o,
  output vfu_pkg::elen_t    result_o,
  output vfu_pkg::vfu_tag_t tag_o
);
  import vfu_pkg::*;

  logic     valid_s1_q;
  vop_e     op_s1_q;
  vew_e     sew_s1_q;
  elen_t    a_s1_q;
  elen_t    b_s1_q;
  vfu_tag_t tag_s1_q;
  elen_t    simd_res;

  // Operands arrive sign extended, so min and max are signed compares
  function automatic elen_t elem_op(vop_e op, elen_t a, elen_t b);
    elen_t res;
    unique case (op)
      VADD:    res = a + b;
      VSUB:    res = a - b;
      VAND:    res = a & b;
      VOR:     res = a | b;
      VXOR:    res = a ^ b;
      VMIN:    res = ($signed(a) < $signed(b)) ? a : b;
      VMAX:    res = ($signed(a) < $signed(b)) ? b : a;
      default: res = '0;
    endcase
    return res;
  endfunction

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_s1_q <= 1'b0;
      valid_o    <= 1'b0;
    end else begin
      valid_s1_q <= valid_i;
      valid_o    <= valid_s1_q;
    end
  end

  always_ff @(posedge clk_i) begin
    op_s1_q  <= op_i;
    sew_s1_q <= sew_i;
    a_s1_q   <= a_i;
    b_s1_q   <= b_i;
    tag_s1_q <= tag_i;
    result_o <= simd_res;
    tag_o    <= tag_s1_q;
  end

  always_comb begin : simd_proc
    elen_t tmp;
    tmp      = '0;
    simd_res = '0;
    unique case (sew_s1_q)
      EW_8: begin
        for (int i = 0; i < `VFU_ELEN/8; i++) begin
          tmp = elem_op(op_s1_q, elen_t'(signed'(a_s1_q[8*i +: 8])),
                        elen_t'(signed'(b_s1_q[8*i +: 8])));
          simd_res[8*i +: 8] = tmp[7:0];
        end
      end
      EW_16: begin
        for (int i = 0; i < `VFU_ELEN/16; i++) begin
          tmp = elem_op(op_s1_q, elen_t'(signed'(a_s1_q[16*i +: 16])),
                        elen_t'(signed'(b_s1_q[16*i +: 16])));
          simd_res[16*i +: 16] = tmp[15:0];
        end
      end
      default: simd_res = elem_op(op_s1_q, a_s1_q, b_s1_q);
    endcase
  end

  a_valid_latency : assert property (
    @(posedge clk_i) disable iff (!arst_n_i) valid_o == $past(valid_i, 2)
  );

endmodule

`default_nettype wire

//--- logic/vfu_result.sv
// Expects at most one response outstanding; a new last word must not arrive while one is held
`timescale 1ns/1ps
`default_nettype none

`include "vfu_params.svh"

module vfu_result (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [`VFU_N_LANES-1:0] lane_valid_i,
  input  vfu_pkg::vword_t         lane_result_i,
  input  vfu_pkg::vfu_tag_t       tag_i,
  input  vfu_pkg::vid_t           req_id_i,
  input  vfu_pkg::gpr_t           rd_i,
  input  logic                    rsp_ready_i,
  output logic                    vrf_we_o,
  output vfu_pkg::vaddr_t         vrf_waddr_o,
  output vfu_pkg::vword_t         vrf_wdata_o,
  output vfu_pkg::vbe_t           vrf_wbe_o,
  output vfu_pkg::vfu_rsp_t       rsp_o,
  output logic                    rsp_valid_o,
  output logic                    rsp_accepted_o
);
  import vfu_pkg::*;

  logic rsp_load;

  ////////////////////////////////////////////////////////////
  // VRF write
  ////////////////////////////////////////////////////////////

  assign vrf_we_o    = (|lane_valid_i) && !tag_i.wb;
  assign vrf_waddr_o = tag_i.waddr;
  assign vrf_wdata_o = lane_result_i;

  always_comb begin : wbe_proc
    vlen_t nbytes;
    vbe_t  tail_be;
    vbe_t  lane_be;
    // Bytes covered by the valid elements of this word
    nbytes  = tag_i.nelem << tag_i.sew;
    tail_be = ~(vbe_t'('1) << nbytes);
    for (int l = 0; l < `VFU_N_LANES; l++) begin
      lane_be[l*(`VFU_ELEN/8) +: (`VFU_ELEN/8)] = {(`VFU_ELEN/8){lane_valid_i[l]}};
    end
    vrf_wbe_o = vrf_we_o ? (tail_be & lane_be) : '0;
  end

  ////////////////////////////////////////////////////////////
  // Response register
  ////////////////////////////////////////////////////////////

  assign rsp_load       = lane_valid_i[0] && tag_i.last;
  assign rsp_accepted_o = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_valid_o <= 1'b0;
    end else if (rsp_load) begin
      rsp_valid_o <= 1'b1;
    end else if (rsp_accepted_o) begin
      rsp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_load) begin
      rsp_o.id     <= req_id_i;
      rsp_o.rd     <= rd_i;
      rsp_o.wb     <= tag_i.wb;
      // Lane 0 holds the scalar result
      rsp_o.result <= tag_i.wb ? lane_result_i[`VFU_ELEN-1:0] : '0;
    end
  end

  a_rsp_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o))
  );

endmodule

`default_nettype wire

//--- logic/vfu_top.sv
// The VRF must return read data in the cycle of rvalid and always accept a write
`timescale 1ns/1ps
`default_nettype none

`include "vfu_params.svh"

module vfu_top (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Request
  input  vfu_pkg::vfu_req_t       req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  // VRF
  output vfu_pkg::vaddr_t   [1:0] vrf_raddr_o,
  output logic              [1:0] vrf_re_o,
  input  vfu_pkg::vword_t   [1:0] vrf_rdata_i,
  input  logic              [1:0] vrf_rvalid_i,
  output logic                    vrf_we_o,
  output vfu_pkg::vaddr_t         vrf_waddr_o,
  output vfu_pkg::vword_t         vrf_wdata_o,
  output vfu_pkg::vbe_t           vrf_wbe_o,
  // Response
  output vfu_pkg::vfu_rsp_t       rsp_o,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i
);
  import vfu_pkg::*;

  vfu_req_t                req_q;
  logic                    req_valid_q;
  logic                    req_done;
  vaddr_t                  waddr;
  vlen_t                   elem_cnt;
  logic                    issue;
  vword_t                  op1;
  vword_t                  op2;
  vfu_tag_t                in_tag;
  logic [`VFU_N_LANES-1:0] in_valid;
  logic [`VFU_N_LANES-1:0] out_valid;
  vword_t                  out_result;
  vfu_tag_t                out_tag [`VFU_N_LANES];
  logic                    rsp_accepted;

  ////////////////////////////////////////////////////////////
  // Request queue
  ////////////////////////////////////////////////////////////

  assign req_ready_o = !req_valid_q || req_done;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_valid_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      req_valid_q <= 1'b1;
    end else if (req_done) begin
      req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
  end

  vfu_sequencer u_seq (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_i         (req_q),
    .req_valid_i   (req_valid_q),
    .vrf_rvalid_i  (vrf_rvalid_i),
    .rsp_ready_i   (rsp_ready_i),
    .rsp_accepted_i(rsp_accepted),
    .req_done_o    (req_done),
    .vrf_re_o      (vrf_re_o),
    .vrf_raddr_o   (vrf_raddr_o),
    .waddr_o       (waddr),
    .elem_cnt_o    (elem_cnt),
    .issue_o       (issue)
  );

  vfu_decode u_dec (
    .req_i       (req_q),
    .vrf_rdata_i (vrf_rdata_i),
    .waddr_i     (waddr),
    .elem_cnt_i  (elem_cnt),
    .issue_i     (issue),
    .op1_o       (op1),
    .op2_o       (op2),
    .tag_o       (in_tag),
    .lane_valid_o(in_valid)
  );

  ////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////

  for (genvar l = 0; l < `VFU_N_LANES; l++) begin : gen_lanes
    // vs2 is the minuend, so it goes on a
    vfu_lane u_lane (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .valid_i (in_valid[l]),
      .op_i    (req_q.op),
      .sew_i   (req_q.sew),
      .a_i     (op2[l*`VFU_ELEN +: `VFU_ELEN]),
      .b_i     (op1[l*`VFU_ELEN +: `VFU_ELEN]),
      .tag_i   (in_tag),
      .valid_o (out_valid[l]),
      .result_o(out_result[l*`VFU_ELEN +: `VFU_ELEN]),
      .tag_o   (out_tag[l])
    );

    // Lanes run in lockstep behind lane 0
    a_lane_lockstep : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      out_valid[l] |-> (out_valid[0] && out_tag[l] == out_tag[0])
    );
  end

  vfu_result u_res (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .lane_valid_i  (out_valid),
    .lane_result_i (out_result),
    .tag_i         (out_tag[0]),
    .req_id_i      (req_q.id),
    .rd_i          (req_q.rd),
    .rsp_ready_i   (rsp_ready_i),
    .vrf_we_o      (vrf_we_o),
    .vrf_waddr_o   (vrf_waddr_o),
    .vrf_wdata_o   (vrf_wdata_o),
    .vrf_wbe_o     (vrf_wbe_o),
    .rsp_o         (rsp_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_accepted_o(rsp_accepted)
  );

endmodule

`default_nettype wire

//--- verif/vfu_tb.sv
// Self-checking testbench; every request keeps vd apart from vs1 and vs2, so sources never alias results
`timescale 1ns/1ps
`default_nettype none

`include "vfu_params.svh"

module vfu_tb;
  import vfu_pkg::*;

  localparam int VRF_WORDS = `VFU_NR_VREGS * `VFU_WORDS_PER_VREG;
  localparam int KIND_VV   = 0;
  localparam int KIND_VX   = 1;
  localparam int KIND_SC   = 2;
  localparam int N_RAND    = 20;
  // Requests over all tests
  localparam int N_REQ     = 7 + 14 + 4 + 9 + N_RAND;
  // Words per request plus handshake overhead, times an allowance for stalls
  localparam int TIMEOUT_CYCLES = 100 + N_REQ * (`VFU_WORDS_PER_VREG + 8) * 8;

  typedef struct packed {
    vaddr_t addr;
    vword_t data;
    vbe_t   be;
  } wr_exp_t;

  logic         clk;
  logic         arst_n_i;
  vfu_req_t     req_i;
  logic         req_valid_i;
  logic         req_ready_o;
  vaddr_t [1:0] vrf_raddr_o;
  logic   [1:0] vrf_re_o;
  vword_t [1:0] vrf_rdata_i;
  logic   [1:0] vrf_rvalid_i;
  logic         vrf_we_o;
  vaddr_t       vrf_waddr_o;
  vword_t       vrf_wdata_o;
  vbe_t         vrf_wbe_o;
  vfu_rsp_t     rsp_o;
  logic         rsp_valid_o;
  logic         rsp_ready_i;

  vword_t      vrf_mem [VRF_WORDS];
  // Reference copy of the VRF, updated as expected writes are queued
  vword_t      gold    [VRF_WORDS];
  wr_exp_t     wr_q    [$];
  vfu_rsp_t    rsp_q   [$];
  logic [31:0] rng_stim;
  logic [31:0] rng_stall;
  logic        stall_en;
  vid_t        next_id;
  int          n_checks;
  int          n_errors;
  int          n_tests;
  int          test_err_base;
  int          cycles;
  logic        rsp_held;
  vfu_rsp_t    rsp_prev;

  vfu_top dut0 (
    .clk_i       (clk),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .vrf_raddr_o (vrf_raddr_o),
    .vrf_re_o    (vrf_re_o),
    .vrf_rdata_i (vrf_rdata_i),
    .vrf_rvalid_i(vrf_rvalid_i),
    .vrf_we_o    (vrf_we_o),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

  initial begin : clk_proc
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [31:0] next_stim();
    rng_stim = xorshift32(rng_stim);
    return rng_stim;
  endfunction

  // Every address bit feeds each lane word of the fill pattern
  function automatic vword_t fill_word(int a);
    vword_t w;
    for (int l = 0; l < `VFU_N_LANES; l++) begin
      w[l*`VFU_ELEN +: `VFU_ELEN] = xorshift32(32'hb4c4 + a * `VFU_N_LANES + l);
    end
    return w;
  endfunction

  function automatic int full_vl(vew_e sew);
    return `VFU_WORDS_PER_VREG * (`VFU_N_LANES * `VFU_ELEN / (8 << int'(sew)));
  endfunction

  function automatic logic [63:0] byte_mask(vbe_t be);
    logic [63:0] m;
    m = '0;
    for (int b = 0; b < $bits(vbe_t); b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  // One element, operands sign extended from ebits, result wrapped to ebits
  function automatic logic [31:0] ref_elem(vop_e op, logic [31:0] a, logic [31:0] b,
                                           int ebits);
    int sa;
    int sb;
    int r;
    sa = $signed(a << (32 - ebits)) >>> (32 - ebits);
    sb = $signed(b << (32 - ebits)) >>> (32 - ebits);
    case (op)
      VADD:    r = sa + sb;
      VSUB:    r = sa - sb;
      VAND:    r = sa & sb;
      VOR:     r = sa | sb;
      VXOR:    r = sa ^ sb;
      VMIN:    r = (sa < sb) ? sa : sb;
      VMAX:    r = (sa > sb) ? sa : sb;
      default: r = 0;
    endcase
    return (ebits == 32) ? r : (r & ((1 << ebits) - 1));
  endfunction

  // vs2 elements on a, vs1 elements or the scalar rs1 on b
  function automatic vword_t ref_word(vfu_req_t r, vword_t src2, vword_t src1, int nel);
    int          ebits;
    vword_t      res;
    logic [31:0] a;
    logic [31:0] b;
    ebits = 8 << int'(r.sew);
    res   = '0;
    for (int e = 0; e < nel; e++) begin
      a   = elen_t'(src2 >> (e * ebits));
      b   = r.use_vs1 ? elen_t'(src1 >> (e * ebits)) : r.rs1;
      res = res | (vword_t'(ref_elem(r.op, a, b, ebits)) << (e * ebits));
    end
    return res;
  endfunction

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic add_expected(input vfu_req_t r);
    int       ebits;
    int       epw;
    int       nwords;
    int       nel;
    int       nbytes;
    wr_exp_t  we;
    vfu_req_t rq;
    vfu_rsp_t re;
    ebits = 8 << int'(r.sew);
    epw   = `VFU_N_LANES * `VFU_ELEN / ebits;
    re    = '0;
    re.id = r.id;
    re.rd = r.rd;
    if (r.is_scalar) begin
      // rs2 on a and rs1 on b, element by element within one lane
      rq         = r;
      rq.use_vs1 = 1'b1;
      re.wb      = 1'b1;
      re.result  = elen_t'(ref_word(rq, vword_t'(r.rs2), vword_t'(r.rs1), `VFU_ELEN / ebits));
    end else begin
      nwords = (int'(r.vl) + epw - 1) / epw;
      for (int w = 0; w < nwords; w++) begin
        nel = int'(r.vl) - w * epw;
        if (nel > epw) begin
          nel = epw;
        end
        nbytes  = nel * ebits / 8;
        we.addr = vaddr_t'(int'(r.vd) * `VFU_WORDS_PER_VREG + w);
        we.data = ref_word(r, gold[int'(r.vs2) * `VFU_WORDS_PER_VREG + w],
                           gold[int'(r.vs1) * `VFU_WORDS_PER_VREG + w], epw);
        we.be   = vbe_t'((1 << nbytes) - 1);
        for (int b = 0; b < $bits(vbe_t); b++) begin
          if (we.be[b]) begin
            gold[we.addr][8*b +: 8] = we.data[8*b +: 8];
          end
        end
        wr_q.push_back(we);
      end
    end
    rsp_q.push_back(re);
  endtask

  task automatic send_req(input vfu_req_t r);
    @(posedge clk);
    req_i       <= r;
    req_valid_i <= 1'b1;
    @(negedge clk);
    while (!req_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
    req_valid_i <= 1'b0;
  endtask

  // vl of 0 selects a full register
  task automatic run_req(input vop_e op, input vew_e sew, input int vl, input int kind);
    vfu_req_t r;
    r           = '0;
    r.id        = next_id;
    r.op        = op;
    r.sew       = sew;
    r.vl        = vlen_t'((vl == 0) ? full_vl(sew) : vl);
    r.vs2       = vreg_t'(next_stim());
    r.vs1       = vreg_t'(int'(r.vs2) + 1 + int'(next_stim() % 15));
    r.vd        = vreg_t'(int'(r.vs2) + 16 + int'(next_stim() % 8));
    r.rd        = gpr_t'(next_stim());
    r.rs1       = next_stim();
    r.rs2       = next_stim();
    r.use_vs1   = (kind == KIND_VV);
    r.is_scalar = (kind == KIND_SC);
    if (r.is_scalar) begin
      r.vl = vlen_t'(1);
    end
    next_id++;
    add_expected(r);
    send_req(r);
  endtask

  task automatic finish_test(input string name);
    @(negedge clk);
    while (wr_q.size() != 0 || rsp_q.size() != 0) begin
      @(negedge clk);
    end
    n_tests++;
    $display("Test %0d %s done, %0d errors", n_tests, name, n_errors - test_err_base);
    test_err_base = n_errors;
  endtask

  ////////////////////////////////////////////////////////////
  // VRF model, stalls and checking
  ////////////////////////////////////////////////////////////

  assign vrf_rdata_i[0] = vrf_mem[vrf_raddr_o[0]];
  assign vrf_rdata_i[1] = vrf_mem[vrf_raddr_o[1]];

  always @(posedge clk) begin : vrf_write_proc
    if (vrf_we_o) begin
      for (int b = 0; b < $bits(vbe_t); b++) begin
        if (vrf_wbe_o[b]) begin
          vrf_mem[vrf_waddr_o][8*b +: 8] <= vrf_wdata_o[8*b +: 8];
        end
      end
    end
  end

  always @(posedge clk) begin : stall_proc
    if (stall_en) begin
      rng_stall = xorshift32(rng_stall);
      vrf_rvalid_i <= {rng_stall[3:2] != 2'b00, rng_stall[1:0] != 2'b00};
      rsp_ready_i  <= rng_stall[5:4] != 2'b00;
    end else begin
      vrf_rvalid_i <= 2'b11;
      rsp_ready_i  <= 1'b1;
    end
  end

  // Mid-cycle sampling, all inputs settled
  always @(negedge clk) begin : compare_proc
    wr_exp_t     we;
    vfu_rsp_t    re;
    logic [63:0] mask;
    if (arst_n_i) begin
      if (vrf_we_o) begin
        if (wr_q.size() == 0) begin
          n_errors++;
          $display("Unexpected VRF write to address %0d at %0t", vrf_waddr_o, $time);
        end else begin
          we   = wr_q.pop_front();
          mask = byte_mask(we.be);
          check_eq("VRF write address", vrf_waddr_o, we.addr);
          check_eq("VRF byte enables", vrf_wbe_o, we.be);
          check_eq("VRF write data", vrf_wdata_o & mask, we.data & mask);
        end
      end
      if (rsp_held) begin
        check_eq("held response valid", rsp_valid_o, 1);
        check_eq("held response", rsp_o, rsp_prev);
      end
      if (rsp_valid_o && rsp_ready_i) begin
        if (rsp_q.size() == 0) begin
          n_errors++;
          $display("Unexpected response with id %0d at %0t", rsp_o.id, $time);
        end else begin
          re = rsp_q.pop_front();
          check_eq("response", rsp_o, re);
        end
      end
      rsp_held = rsp_valid_o && !rsp_ready_i;
      rsp_prev = rsp_o;
    end
  end

  always @(posedge clk) begin : timeout_proc
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin : main_proc
    vew_e sew_r;
    vop_e op_r;
    int   kind_r;
    int   vl_r;
    arst_n_i      = 1'b0;
    req_i         = '0;
    req_valid_i   = 1'b0;
    vrf_rvalid_i  = 2'b11;
    rsp_ready_i   = 1'b1;
    stall_en      = 1'b0;
    rng_stim      = 32'hb4c4;
    // Separate stall stream derived from the same seed
    rng_stall     = 32'hb4c4 * 32'h9e37_79b1;
    next_id       = '0;
    n_checks      = 0;
    n_errors      = 0;
    n_tests       = 0;
    test_err_base = 0;
    cycles        = 0;
    rsp_held      = 1'b0;
    rsp_prev      = '0;
    for (int a = 0; a < VRF_WORDS; a++) begin
      vrf_mem[a] = fill_word(a);
      gold[a]    = fill_word(a);
    end

    repeat (10) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);
    check_eq("req_ready_o after reset", req_ready_o, 1);
    check_eq("vrf_we_o after reset", vrf_we_o, 0);
    check_eq("vrf_re_o after reset", vrf_re_o, 0);
    check_eq("rsp_valid_o after reset", rsp_valid_o, 0);
    finish_test("reset state");

    for (int o = 0; o < 7; o++) begin
      run_req(vop_e'(3'(o)), EW_32, 0, KIND_VV);
    end
    finish_test("sew32 vector-vector");

    for (int o = 0; o < 7; o++) begin
      run_req(vop_e'(3'(o)), EW_8, 0, KIND_VV);
      run_req(vop_e'(3'(o)), EW_16, 0, KIND_VV);
    end
    finish_test("sew8 and sew16");

    run_req(VADD, EW_8, 13, KIND_VV);
    run_req(VSUB, EW_16, 7, KIND_VV);
    run_req(VXOR, EW_32, 5, KIND_VV);
    run_req(VMAX, EW_8, 3, KIND_VX);
    finish_test("tail byte enables");

    for (int s = 0; s < 3; s++) begin
      run_req(vop_e'(3'(next_stim() % 7)), vew_e'(2'(s)), 0, KIND_VX);
      run_req(vop_e'(3'(next_stim() % 7)), vew_e'(2'(s)), 0, KIND_SC);
      run_req(vop_e'(3'(next_stim() % 7)), vew_e'(2'(s)), 0, KIND_SC);
    end
    finish_test("vector-scalar and scalar");

    stall_en = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      sew_r  = vew_e'(2'(next_stim() % 3));
      op_r   = vop_e'(3'(next_stim() % 7));
      kind_r = int'(next_stim() % 3);
      vl_r   = 1 + int'(next_stim() % full_vl(sew_r));
      run_req(op_r, sew_r, vl_r, kind_r);
    end
    finish_test("random stalls");
    stall_en = 1'b0;

    $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vfu.f
+incdir+logic
logic/vfu_pkg.sv
logic/vfu_decode.sv
logic/vfu_sequencer.sv
logic/vfu_lane.sv
logic/vfu_result.sv
logic/vfu_top.sv
verif/vfu_tb.sv

//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP      ?= vfu_tb
FILELIST ?= vfu.f
OBJ_DIR  ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf $(OBJ_DIR)
